//--- Bender.yml
package:
  name: stream_alu

sources:
  # Design, in compile order
  - rtl/stream_pkg.sv
  - rtl/pipe_stage.sv
  - rtl/stream_alu.sv
  - rtl/stream_top.sv

  # Testbench
  - target: test
    files:
      - bench/tb_clock_gen.sv
      - bench/tb_stream_top.sv

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ns

// Clock and reset source for the testbench
module tb_clock_gen #(
    parameter int half_period = 10,  // 20 ns clock
    parameter int rst_cycles  = 10   // Reset length in cycles
) (
    output logic clk,
    output logic sig_rst  // Active low
);

    initial clk = 1'b0;

    always #half_period clk = ~clk;

    // Release 2 ns after an edge, like all other stimulus
    initial begin
        sig_rst = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        #2;
        sig_rst = 1'b1;
    end

endmodule

//--- bench/tb_stream_top.sv
`timescale 1ns/1ns

module tb_stream_top;

    import stream_pkg::*;

    // Tests take well under a quarter of this
    localparam int timeout_cycles = 5000;

    logic                  clk;
    logic                  sig_rst;
    alu_op_t               op;
    logic [data_width-1:0] operand;
    logic                  acc_clr;
    logic [data_width-1:0] in_data;
    logic                  in_valid;
    logic                  in_ready;
    logic [data_width-1:0] out_data;
    logic                  out_valid;
    logic                  out_ready;

    integer                seed = 32'haf947efa;  // Fixed seed for all $random calls
    logic [data_width-1:0] expect_q[$];          // Expected results in order
    logic [data_width-1:0] model_acc = '0;       // Reference running sum
    logic [data_width-1:0] exp_word;
    int                    in_count = 0;
    int                    out_count = 0;
    int                    cycle_cnt = 0;
    logic                  ready_rand = 1'b0;    // Random out_ready pattern on
    logic                  ready_level = 1'b1;   // out_ready level when not random
    logic                  ready_next;           // out_ready value for the next cycle

    tb_clock_gen u_clock_gen (
        .clk     (clk),
        .sig_rst (sig_rst)
    );

    stream_top UUT (
        .clk       (clk),
        .sig_rst   (sig_rst),
        .op        (op),
        .operand   (operand),
        .acc_clr   (acc_clr),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    //////////////////////////////////////////////////
    // Failure handling and checks
    //////////////////////////////////////////////////

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_failure($sformatf("Error: %s = 0x%h, expected 0x%h",
                                        name, actual, expected));
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model and scoreboard
    //////////////////////////////////////////////////

    // Expected result for one accepted word
    function automatic logic [data_width-1:0] predict_word(
        input alu_op_t               sel,
        input logic [data_width-1:0] opnd,
        input logic [data_width-1:0] word,
        input logic [data_width-1:0] sum   // Running sum with this word
    );
        case (sel)
            op_add:  predict_word = word + opnd;  // Wraps at 16 bits
            op_xor:  predict_word = word ^ opnd;
            op_acc:  predict_word = sum;
            default: predict_word = word;
        endcase
    endfunction

    // Input monitor that sums every accepted word
    always @(posedge clk) begin
        if (sig_rst) begin
            if (acc_clr) begin
                model_acc = '0;  // Clear first so a same-edge word restarts the sum
            end
            if (in_valid && in_ready) begin
                model_acc = model_acc + in_data;
                expect_q.push_back(predict_word(op, operand, in_data, model_acc));
                in_count++;
            end
        end
    end

    // Output checker pops one expected word per transfer
    always @(posedge clk) begin
        if (sig_rst && out_valid && out_ready) begin
            if (expect_q.size() == 0) begin
                stop_with_failure("Output word appeared with no word expected");
            end else begin
                exp_word = expect_q.pop_front();
                out_count++;
                check_value("out_data", out_data, exp_word);
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= timeout_cycles) begin
            stop_with_failure("Timeout: run did not finish within the cycle limit");
        end
    end

    // out_ready pattern drawn at the edge and driven 2 ns later
    always @(posedge clk) begin
        ready_next = ready_rand ? (($random(seed) & 3) != 0) : ready_level;
        #2;
        out_ready = ready_next;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Offer one word and hold it until accepted
    task automatic send_word(input logic [data_width-1:0] word);
        logic accepted;
        in_data  = word;
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = in_ready;  // Pre-edge value
        end
        #2;
    endtask

    task automatic send_random_words(input int count);
        for (int i = 0; i < count; i++) begin
            send_word($random(seed));
        end
        in_valid = 1'b0;
    endtask

    // Hold ready high until no output for 4 cycles
    // All words must have come out by then
    task automatic wait_drain();
        int idle;
        ready_rand  = 1'b0;
        ready_level = 1'b1;
        idle        = 0;
        while (idle < 4) begin
            @(posedge clk);
            if (out_valid && out_ready) idle = 0;
            else idle++;
        end
        #2;
        check_value("pending words", expect_q.size(), 0);
        check_value("output count", out_count, in_count);
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset();
        check_value("out_valid", out_valid, 1'b0);
        check_value("in_ready", in_ready, 1'b1);
    endtask

    task automatic test_pass();
        op = op_pass;
        send_random_words(64);  // out_ready held high
        wait_drain();
    endtask

    task automatic test_add_xor();
        op         = op_add;
        operand    = $random(seed);
        ready_rand = 1'b1;
        send_random_words(48);
        wait_drain();               // Operand only moves on an empty chain
        op         = op_xor;
        operand    = $random(seed);
        ready_rand = 1'b1;
        send_random_words(48);
        wait_drain();
    endtask

    // Clear pulse on an idle cycle
    task automatic pulse_clear();
        acc_clr = 1'b1;
        @(posedge clk);
        #2;
        acc_clr = 1'b0;
    endtask

    task automatic test_accumulate();
        op = op_acc;
        pulse_clear();
        ready_rand = 1'b1;
        send_random_words(20);
        wait_drain();
        pulse_clear();              // Mid-sequence restart from zero
        ready_rand = 1'b1;
        send_random_words(20);
        wait_drain();
    endtask

    task automatic test_backpressure();
        int accepted;
        op          = op_pass;
        ready_level = 1'b0;
        @(posedge clk);
        #2;                         // out_ready now low
        accepted = 0;
        in_data  = $random(seed);
        in_valid = 1'b1;
        repeat (8) begin
            @(posedge clk);
            if (in_ready) begin
                accepted++;
                #2;
                in_data = $random(seed);  // Next word only after a transfer
            end else begin
                #2;
            end
        end
        check_value("accepted words", accepted, pipe_depth);
        check_value("in_ready", in_ready, 1'b0);
        in_valid = 1'b0;
        wait_drain();               // Held words leave in order
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        op        = op_pass;
        operand   = '0;
        acc_clr   = 1'b0;
        in_data   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b1;

        @(posedge sig_rst);
        @(posedge clk);
        #2;

        test_reset();
        test_pass();
        test_add_xor();
        test_accumulate();
        test_backpressure();

        if (expect_q.size() != 0) begin
            stop_with_failure("Words were left in the pipeline at the end");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- list.f
rtl/stream_pkg.sv
rtl/pipe_stage.sv
rtl/stream_alu.sv
rtl/stream_top.sv
bench/tb_clock_gen.sv
bench/tb_stream_top.sv

//--- rtl/pipe_stage.sv
`timescale 1ns/1ns

// One-word register slice on a valid-ready link
// Acts as a FIFO of depth one with full throughput
module pipe_stage #(
    parameter int data_width = 8  // Word width on both sides
) (
    input  logic                  clk,
    input  logic                  sig_rst,  // Async, active low

    // Write side, from upstream
    input  logic [data_width-1:0] wdata,
    input  logic                  wvalid,
    output logic                  wready,

    // Read side, to downstream
    output logic [data_width-1:0] rdata,
    output logic                  rvalid,
    input  logic                  rready
);

    //////////////////////////////////////////////////
    // Internal signals
    //////////////////////////////////////////////////

    logic [data_width-1:0] data_q;   // Held word
    logic                  valid_q;  // Held word is valid
    logic                  empty;    // Nothing held
    logic                  wr_en;    // Write transfer this cycle
    logic                  rd_en;    // Read transfer this cycle

    //////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////

    assign empty  = ~valid_q;
    // Take a new word when empty or when the held one leaves now
    assign wready = rready | empty;   // Combinational back-pressure path
    assign wr_en  = wvalid & wready;
    assign rd_en  = valid_q & rready;

    //////////////////////////////////////////////////
    // Data register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_q <= wdata;  // Load on write transfer
        end
    end

    //////////////////////////////////////////////////
    // Valid flag
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge sig_rst) begin
        if (!sig_rst) begin
            valid_q <= 1'b0;  // Empty after reset
        end else begin
            if (wr_en) begin
                valid_q <= 1'b1;  // New word in, also covers write+read
            end else if (rd_en) begin
                valid_q <= 1'b0;  // Last word out, none in
            end
        end
    end

    // Read side outputs
    assign rvalid = valid_q;
    assign rdata  = data_q;

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Stalled word must not change under the consumer
    property p_rdata_hold;
        @(posedge clk) disable iff (!sig_rst)
            (rvalid && !rready) |=> (rvalid && $stable(rdata));
    endproperty

    a_rdata_hold : assert property (p_rdata_hold)
        else $error("pipe_stage: rdata changed while stalled");

endmodule

//--- rtl/stream_alu.sv
`timescale 1ns/1ns

// Processing stage of the stream
// Computes the selected operation on each accepted word and
// registers the result, one cycle of latency
module stream_alu (
    input  logic                                clk,
    input  logic                                sig_rst,  // Async, active low

    // Control levels, stable while words are in flight
    input  stream_pkg::alu_op_t                 op,
    input  logic [stream_pkg::data_width-1:0]   operand,
    input  logic                                acc_clr,  // Accumulator clear pulse

    // Upstream link
    input  logic [stream_pkg::data_width-1:0]   in_data,
    input  logic                                in_valid,
    output logic                                in_ready,

    // Downstream link
    output logic [stream_pkg::data_width-1:0]   out_data,
    output logic                                out_valid,
    input  logic                                out_ready
);

    import stream_pkg::*;

    //////////////////////////////////////////////////
    // Internal signals
    //////////////////////////////////////////////////

    logic [data_width-1:0] acc_q;     // Running sum of accepted words
    logic [data_width-1:0] acc_base;  // Sum before this word, after clear
    logic [data_width-1:0] acc_sum;   // Sum including this word
    logic [data_width-1:0] result;    // Value written into the stage
    logic                  in_xfer;   // Word accepted this cycle

    // Ready comes straight from the output register slice
    assign in_xfer = in_valid & in_ready;

    //////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////

    // A clear at the same edge as a word makes the sum restart
    // from that word
    always_comb begin
        acc_base = acc_clr ? '0 : acc_q;
        acc_sum  = acc_base + in_data;  // Wraps at 2**data_width
    end

    always_comb begin
        case (op)
            op_pass: result = in_data;
            op_add:  result = in_data + operand;  // Modulo add
            op_xor:  result = in_data ^ operand;
            op_acc:  result = acc_sum;            // Sum with this word
            default: result = in_data;            // X on op, pass through
        endcase
    end

    //////////////////////////////////////////////////
    // Accumulator
    //////////////////////////////////////////////////

    // Tracks every accepted word, whatever op is selected
    always_ff @(posedge clk or negedge sig_rst) begin
        if (!sig_rst) begin
            acc_q <= '0;
        end else begin
            if (in_xfer) begin
                acc_q <= acc_sum;  // Includes clear when both at once
            end else if (acc_clr) begin
                acc_q <= '0;       // Clear on an idle edge
            end
        end
    end

    //////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////

    // Holds the result and drives the downstream link
    pipe_stage #(
        .data_width (data_width)
    ) u_res_stage (
        .clk     (clk),
        .sig_rst (sig_rst),
        .wdata   (result),
        .wvalid  (in_valid),
        .wready  (in_ready),   // Ready path back to upstream
        .rdata   (out_data),
        .rvalid  (out_valid),
        .rready  (out_ready)
    );

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Opcode must be driven whenever a word is offered
    property p_op_known;
        @(posedge clk) disable iff (!sig_rst)
            in_valid |-> !$isunknown(op);
    endproperty

    a_op_known : assert property (p_op_known)
        else $error("stream_alu: op unknown with in_valid high");

endmodule

//--- rtl/stream_pkg.sv
package stream_pkg;

    //////////////////////////////////////////////////
    // Stream geometry
    //////////////////////////////////////////////////

    // Width of every stream word and of the operand
    localparam int data_width = 16;

    // Register stages between in_data and out_data
    // Input stage, ALU stage and output stage
    localparam int pipe_depth = 3;

    //////////////////////////////////////////////////
    // ALU opcodes
    //////////////////////////////////////////////////

    // Selected by the op level at the ALU stage
    // Only changed while the pipeline is empty
    typedef enum logic [1:0] {
        op_pass = 2'd0,  // Word goes through untouched
        op_add  = 2'd1,  // Word plus operand, wraps at 2**data_width
        op_xor  = 2'd2,  // Word xor operand
        op_acc  = 2'd3   // Running sum including current word
    } alu_op_t;

endpackage

//--- rtl/stream_top.sv
`timescale 1ns/1ns

// Streaming arithmetic unit
// Input stage, ALU stage and output stage on valid-ready links
module stream_top (
    input  logic                                clk,
    input  logic                                sig_rst,  // Async, active low

    // Control levels and clear pulse
    input  stream_pkg::alu_op_t                 op,
    input  logic [stream_pkg::data_width-1:0]   operand,
    input  logic                                acc_clr,

    // Input stream
    input  logic [stream_pkg::data_width-1:0]   in_data,
    input  logic                                in_valid,
    output logic                                in_ready,

    // Output stream
    output logic [stream_pkg::data_width-1:0]   out_data,
    output logic                                out_valid,
    input  logic                                out_ready
);

    import stream_pkg::*;

    //////////////////////////////////////////////////
    // Chain links
    //////////////////////////////////////////////////

    logic [data_width-1:0] ing_data;   // Input stage to ALU
    logic                  ing_valid;
    logic                  ing_ready;
    logic [data_width-1:0] alu_data;   // ALU to output stage
    logic                  alu_valid;
    logic                  alu_ready;

    //////////////////////////////////////////////////
    // Stages
    //////////////////////////////////////////////////

    pipe_stage #(
        .data_width (data_width)
    ) u_ing_stage (
        .clk     (clk),
        .sig_rst (sig_rst),
        .wdata   (in_data),
        .wvalid  (in_valid),
        .wready  (in_ready),
        .rdata   (ing_data),
        .rvalid  (ing_valid),
        .rready  (ing_ready)
    );

    stream_alu u_alu (
        .clk       (clk),
        .sig_rst   (sig_rst),
        .op        (op),
        .operand   (operand),
        .acc_clr   (acc_clr),
        .in_data   (ing_data),
        .in_valid  (ing_valid),
        .in_ready  (ing_ready),
        .out_data  (alu_data),
        .out_valid (alu_valid),
        .out_ready (alu_ready)
    );

    pipe_stage #(
        .data_width (data_width)
    ) u_egr_stage (
        .clk     (clk),
        .sig_rst (sig_rst),
        .wdata   (alu_data),
        .wvalid  (alu_valid),
        .wready  (alu_ready),
        .rdata   (out_data),
        .rvalid  (out_valid),
        .rready  (out_ready)
    );

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    logic [$clog2(pipe_depth+1)-1:0] held_cnt;  // Words inside the chain

    always_ff @(posedge clk or negedge sig_rst) begin
        if (!sig_rst) begin
            held_cnt <= '0;
        end else begin
            case ({in_valid & in_ready, out_valid & out_ready})
                2'b10:   held_cnt <= held_cnt + 1'b1;  // In only
                2'b01:   held_cnt <= held_cnt - 1'b1;  // Out only
                default: held_cnt <= held_cnt;         // Both or neither
            endcase
        end
    end

    // Some stage is free below full depth, so ready must stay up
    a_ready_depth : assert property (
        @(posedge clk) disable iff (!sig_rst)
            (held_cnt < pipe_depth) |-> in_ready
    ) else $error("stream_top: in_ready low with %0d words held", held_cnt);

endmodule
